// File: conv_loop_top.f
+incdir+testbench
hdl/conv_geom_pkg.sv
hdl/conv_stream_pkg.sv
hdl/conv_loop_ctrl.sv
hdl/frame_load.sv
hdl/frame_store.sv
hdl/replay_scan.sv
hdl/pixel_out_stage.sv
hdl/conv_loop_top.sv
testbench/tb_conv_loop.sv

// File: hdl/conv_geom_pkg.sv
package conv_geom_pkg;

	////////////////////////////////////////
	// Image geometry
	////////////////////////////////////////

	// Pixels per image row
	localparam int IMAGE_WIDTH = 4;

	// Pixels per channel, square image
	localparam int IMAGE_SIZE = IMAGE_WIDTH * IMAGE_WIDTH;

	////////////////////////////////////////
	// Channel geometry
	////////////////////////////////////////

	localparam int IN_CHANNELS  = 3;
	// One replay pass per output channel
	localparam int OUT_CHANNELS = 4;

	// Padding rate of the downstream kernel window
	localparam int PAD_RATE = 1;

	// Idle cycles after each channel so the window can drain
	localparam int CHANNEL_GAP = IMAGE_WIDTH * PAD_RATE + PAD_RATE;

	// Derived counts
	localparam int FRAME_PIXELS = IN_CHANNELS * IMAGE_SIZE;
	localparam int SLOT_LEN     = IMAGE_SIZE + CHANNEL_GAP;

	localparam int PIXEL_BITS = 16;

endpackage

// File: hdl/conv_loop_ctrl.sv
module conv_loop_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic frame_loaded,
	input  logic scan_done,
	output logic load_en,
	output logic scan_start,
	output logic busy
);

	typedef enum logic {
		LOAD,
		REPLAY
	} loop_state_t;

	loop_state_t state;

	// Counts down the output pipeline after the last read
	logic [1:0] drain_cnt;

	////////////////////////////////////////
	// State machine
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= LOAD;
			scan_start <= 1'b0;
			drain_cnt  <= 2'd0;
		end else begin
			scan_start <= 1'b0;
			case (state)
				LOAD: begin
					if (frame_loaded) begin
						state      <= REPLAY;
						scan_start <= 1'b1;
					end
				end
				REPLAY: begin
					// Memory read stage plus output register
					if (scan_done) begin
						drain_cnt <= 2'd2;
					end else if (drain_cnt != 2'd0) begin
						drain_cnt <= drain_cnt - 2'd1;
						if (drain_cnt == 2'd1) begin
							state <= LOAD;
						end
					end
				end
				default: begin
					state <= LOAD;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Outputs
	////////////////////////////////////////

	assign busy = (state == REPLAY);

	// Closed in the frame_loaded cycle so a stray pixel
	// cannot overwrite address zero before the replay starts
	assign load_en = (state == LOAD) && !frame_loaded;

endmodule

// File: hdl/conv_loop_top.sv
module conv_loop_top
	import conv_stream_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   valid_in,
	input  pixel_t pxl_in,
	output pixel_t pxl_out,
	output logic   valid_out,
	output ch_in_t ch_in_out,
	output pass_t  pass_out,
	output logic   last_out,
	output logic   busy
);

	// Control handshake
	logic load_en;
	logic scan_start;
	logic frame_loaded;
	logic scan_done;

	// Write side
	logic        wr_en;
	frame_addr_t wr_addr;
	pixel_t      wr_data;

	// Read side and issue-time tags
	logic        rd_en;
	frame_addr_t rd_addr;
	pixel_t      rd_data;
	ch_in_t      scan_ch_in;
	pass_t       scan_pass;
	logic        scan_last;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	conv_loop_ctrl u_ctrl (
		.clk          (clk),
		.reset        (reset),
		.frame_loaded (frame_loaded),
		.scan_done    (scan_done),
		.load_en      (load_en),
		.scan_start   (scan_start),
		.busy         (busy)
	);

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	frame_load u_load (
		.clk          (clk),
		.reset        (reset),
		.load_en      (load_en),
		.valid_in     (valid_in),
		.pxl_in       (pxl_in),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.frame_loaded (frame_loaded)
	);

	frame_store u_store (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	replay_scan u_scan (
		.clk        (clk),
		.reset      (reset),
		.scan_start (scan_start),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.scan_ch_in (scan_ch_in),
		.scan_pass  (scan_pass),
		.scan_last  (scan_last),
		.scan_done  (scan_done)
	);

	pixel_out_stage u_out (
		.clk        (clk),
		.reset      (reset),
		.rd_en      (rd_en),
		.scan_ch_in (scan_ch_in),
		.scan_pass  (scan_pass),
		.scan_last  (scan_last),
		.rd_data    (rd_data),
		.pxl_out    (pxl_out),
		.valid_out  (valid_out),
		.ch_in_out  (ch_in_out),
		.pass_out   (pass_out),
		.last_out   (last_out)
	);

endmodule

// File: hdl/conv_stream_pkg.sv
package conv_stream_pkg;

	import conv_geom_pkg::*;

	////////////////////////////////////////
	// Stream word types
	////////////////////////////////////////

	// One pixel word
	typedef logic [PIXEL_BITS-1:0] pixel_t;

	// Index into the frame store
	typedef logic [$clog2(FRAME_PIXELS)-1:0] frame_addr_t;

	// Input channel tag
	typedef logic [$clog2(IN_CHANNELS+1)-1:0] ch_in_t;

	// Pass tag, one pass per output channel
	typedef logic [$clog2(OUT_CHANNELS+1)-1:0] pass_t;

	// Position inside one channel slot, pixels then gap
	typedef logic [$clog2(IMAGE_SIZE+CHANNEL_GAP)-1:0] scan_cnt_t;

endpackage

// File: hdl/frame_load.sv
module frame_load
	import conv_geom_pkg::*, conv_stream_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        load_en,
	input  logic        valid_in,
	input  pixel_t      pxl_in,
	output logic        wr_en,
	output frame_addr_t wr_addr,
	output pixel_t      wr_data,
	output logic        frame_loaded
);

	frame_addr_t addr_cnt;
	logic        accept;

	// Pixels offered outside the load window are lost
	assign accept = load_en && valid_in;

	////////////////////////////////////////
	// Write address counter
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			addr_cnt     <= '0;
			frame_loaded <= 1'b0;
		end else begin
			frame_loaded <= 1'b0;
			if (accept) begin
				if (addr_cnt == frame_addr_t'(FRAME_PIXELS - 1)) begin
					// Last pixel of the map
					addr_cnt     <= '0;
					frame_loaded <= 1'b1;
				end else begin
					addr_cnt <= addr_cnt + 1'b1;
				end
			end
		end
	end

	assign wr_en   = accept;
	assign wr_addr = addr_cnt;
	assign wr_data = pxl_in;

endmodule

// File: hdl/frame_store.sv
module frame_store
	import conv_geom_pkg::*, conv_stream_pkg::*;
(
	input  logic        clk,
	input  logic        wr_en,
	input  frame_addr_t wr_addr,
	input  pixel_t      wr_data,
	input  logic        rd_en,
	input  frame_addr_t rd_addr,
	output pixel_t      rd_data
);

	////////////////////////////////////////
	// Storage for one input feature map
	////////////////////////////////////////

	pixel_t mem [0:FRAME_PIXELS-1];

	// Write port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Read port, one cycle latency
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// File: hdl/pixel_out_stage.sv
module pixel_out_stage
	import conv_stream_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   rd_en,
	input  ch_in_t scan_ch_in,
	input  pass_t  scan_pass,
	input  logic   scan_last,
	input  pixel_t rd_data,
	output pixel_t pxl_out,
	output logic   valid_out,
	output ch_in_t ch_in_out,
	output pass_t  pass_out,
	output logic   last_out
);

	logic   rd_en_d;
	logic   last_d;
	ch_in_t ch_d;
	pass_t  pass_d;

	////////////////////////////////////////
	// Match the memory read latency
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_en_d <= 1'b0;
			last_d  <= 1'b0;
		end else begin
			rd_en_d <= rd_en;
			last_d  <= scan_last;
		end
	end

	always_ff @(posedge clk) begin
		ch_d   <= scan_ch_in;
		pass_d <= scan_pass;
	end

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
			last_out  <= 1'b0;
			pxl_out   <= '0;
		end else begin
			valid_out <= rd_en_d;
			last_out  <= rd_en_d && last_d;
			// Idle cycles carry a zero pixel
			pxl_out   <= rd_en_d ? rd_data : '0;
		end
	end

	always_ff @(posedge clk) begin
		ch_in_out <= ch_d;
		pass_out  <= pass_d;
	end

endmodule

// File: hdl/replay_scan.sv
module replay_scan
	import conv_geom_pkg::*, conv_stream_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        scan_start,
	output logic        rd_en,
	output frame_addr_t rd_addr,
	output ch_in_t      scan_ch_in,
	output pass_t       scan_pass,
	output logic        scan_last,
	output logic        scan_done
);

	logic        active;
	scan_cnt_t   pos;
	ch_in_t      ch;
	pass_t       pass;
	// First address of the current channel
	frame_addr_t ch_base;

	logic in_pixels;
	logic last_read;

	assign in_pixels = (pos < scan_cnt_t'(IMAGE_SIZE));
	assign last_read = (pass == pass_t'(OUT_CHANNELS - 1)) &&
		(ch == ch_in_t'(IN_CHANNELS - 1)) &&
		(pos == scan_cnt_t'(IMAGE_SIZE - 1));

	////////////////////////////////////////
	// Slot, channel and pass counters
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			active  <= 1'b0;
			pos     <= '0;
			ch      <= '0;
			pass    <= '0;
			ch_base <= '0;
		end else if (scan_start) begin
			active  <= 1'b1;
			pos     <= '0;
			ch      <= '0;
			pass    <= '0;
			ch_base <= '0;
		end else if (active) begin
			if (last_read) begin
				// Whole map replayed for every output channel
				active  <= 1'b0;
				pos     <= '0;
				ch      <= '0;
				pass    <= '0;
				ch_base <= '0;
			end else if (pos == scan_cnt_t'(SLOT_LEN - 1)) begin
				pos <= '0;
				if (ch == ch_in_t'(IN_CHANNELS - 1)) begin
					// Next pass restarts at the top of the map
					ch      <= '0;
					ch_base <= '0;
					pass    <= pass + 1'b1;
				end else begin
					ch      <= ch + 1'b1;
					ch_base <= ch_base + frame_addr_t'(IMAGE_SIZE);
				end
			end else begin
				pos <= pos + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Read issue
	////////////////////////////////////////

	// Gap positions issue no read
	assign rd_en      = active && in_pixels;
	assign rd_addr    = ch_base + frame_addr_t'(pos);
	assign scan_ch_in = ch;
	assign scan_pass  = pass;
	assign scan_last  = active && last_read;
	assign scan_done  = active && last_read;

endmodule

// File: testbench/tb_conv_loop_ref.svh
`ifndef TB_CONV_LOOP_REF_SVH
`define TB_CONV_LOOP_REF_SVH

// One expected output word
typedef struct packed {
	pixel_t pxl;
	ch_in_t ch;
	pass_t  pass;
	logic   last;
} exp_entry_t;

exp_entry_t  exp_q[$];
pixel_t      frame_buf [0:FRAME_PIXELS-1];
logic [15:0] lfsr_state = 16'd26;

// Galois LFSR, one step per bit taken
function automatic logic next_rand_bit();
	logic lsb;
	lsb = lfsr_state[0];
	lfsr_state = lfsr_state >> 1;
	if (lsb) begin
		lfsr_state = lfsr_state ^ 16'hB400;
	end
	return lsb;
endfunction

function automatic logic [15:0] rand_bits(input int n);
	logic [15:0] val;
	val = '0;
	for (int i = 0; i < n; i++) begin
		val = {val[14:0], next_rand_bit()};
	end
	return val;
endfunction

// Replay of the loaded frame: pass, then channel, then pixel
function automatic void append_replay();
	exp_entry_t e;
	for (int p = 0; p < OUT_CHANNELS; p++) begin
		for (int c = 0; c < IN_CHANNELS; c++) begin
			for (int i = 0; i < IMAGE_SIZE; i++) begin
				e.pxl  = frame_buf[c * IMAGE_SIZE + i];
				e.ch   = ch_in_t'(c);
				e.pass = pass_t'(p);
				e.last = (p == OUT_CHANNELS - 1) && (c == IN_CHANNELS - 1) &&
					(i == IMAGE_SIZE - 1);
				exp_q.push_back(e);
			end
		end
	end
endfunction

`endif

// File: testbench/tb_conv_loop.sv
module tb_conv_loop
	import conv_geom_pkg::*, conv_stream_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 2000;
	// Cycles from busy rising to the first valid_out
	localparam int BUSY_TO_VALID = 3;

	logic   clk;
	logic   reset;
	logic   valid_in;
	pixel_t pxl_in;
	pixel_t pxl_out;
	logic   valid_out;
	ch_in_t ch_in_out;
	pass_t  pass_out;
	logic   last_out;
	logic   busy;

	int mismatch_count = 0;
	int other_count = 0;
	bit timed_out = 1'b0;

	`include "tb_conv_loop_ref.svh"

	conv_loop_top dut0 (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (valid_in),
		.pxl_in    (pxl_in),
		.pxl_out   (pxl_out),
		.valid_out (valid_out),
		.ch_in_out (ch_in_out),
		.pass_out  (pass_out),
		.last_out  (last_out),
		.busy      (busy)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_ch_in(input string name, input ch_in_t got, input ch_in_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_pass(input string name, input pass_t got, input pass_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////

	task automatic note_timeout(input string what);
		other_count++;
		timed_out = 1'b1;
		$display("timeout at %0t while waiting for %s", $time, what);
	endtask

	task automatic wait_busy(input logic level);
		int cnt;
		cnt = 0;
		while (busy !== level && cnt < WAIT_LIMIT) begin
			@(negedge clk);
			cnt++;
		end
		if (busy !== level) begin
			note_timeout(level ? "busy to rise" : "busy to fall");
		end
	endtask

	// Random idle cycles before each pixel unless at_once skips the first
	task automatic load_frame(input bit at_once);
		int gap;
		for (int i = 0; i < FRAME_PIXELS; i++) begin
			gap = (at_once && i == 0) ? 0 : int'(rand_bits(2));
			valid_in = 1'b0;
			repeat (gap) @(negedge clk);
			valid_in = 1'b1;
			pxl_in = rand_bits(PIXEL_BITS);
			frame_buf[i] = pxl_in;
			@(negedge clk);
		end
		valid_in = 1'b0;
		append_replay();
	endtask

	// Strobes during the replay must be dropped
	task automatic replay_with_noise();
		int cnt;
		wait_busy(1'b1);
		if (!timed_out) begin
			cnt = 0;
			while (busy === 1'b1 && cnt < WAIT_LIMIT) begin
				valid_in = next_rand_bit();
				pxl_in = rand_bits(PIXEL_BITS);
				@(negedge clk);
				cnt++;
			end
			valid_in = 1'b0;
			if (busy !== 1'b0) begin
				note_timeout("end of replay");
			end else if (exp_q.size() != 0) begin
				other_count++;
				$display("replay ended at %0t with %0d pixels missing", $time, exp_q.size());
			end
		end
	endtask

	task automatic reset_mid_replay();
		int cnt;
		load_frame(1'b0);
		wait_busy(1'b1);
		if (!timed_out) begin
			cnt = 0;
			while (exp_q.size() > FRAME_PIXELS * OUT_CHANNELS / 2 && cnt < WAIT_LIMIT) begin
				@(negedge clk);
				cnt++;
			end
			if (exp_q.size() > FRAME_PIXELS * OUT_CHANNELS / 2) begin
				note_timeout("half of the replay");
			end else begin
				reset = 1'b1;
				exp_q.delete();
				@(negedge clk);
				check_flag("busy", busy, 1'b0);
				check_flag("valid_out", valid_out, 1'b0);
				repeat (2) @(negedge clk);
				reset = 1'b0;
			end
		end
	endtask

	////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////

	int   cyc = 0;
	int   run_len = 0;
	int   gap_len = 0;
	int   busy_rise_cyc = 0;
	logic busy_prev = 1'b0;
	logic last_prev = 1'b0;
	logic started = 1'b0;

	always @(posedge clk) begin : monitor
		exp_entry_t e;
		cyc++;
		if (reset) begin
			run_len = 0;
			gap_len = 0;
			started = 1'b0;
			busy_prev = 1'b0;
			last_prev = 1'b0;
		end else begin
			if (busy && !busy_prev) begin
				busy_rise_cyc = cyc;
			end
			if (valid_out) begin
				if (!started) begin
					started = 1'b1;
					check_count("busy to valid_out", cyc - busy_rise_cyc, BUSY_TO_VALID);
				end else if (gap_len != 0) begin
					check_count("channel gap", gap_len, CHANNEL_GAP);
				end
				gap_len = 0;
				run_len++;
				if (exp_q.size() == 0) begin
					other_count++;
					$display("valid pixel at %0t with nothing left to expect", $time);
				end else begin
					e = exp_q.pop_front();
					check_pixel("pxl_out", pxl_out, e.pxl);
					check_ch_in("ch_in_out", ch_in_out, e.ch);
					check_pass("pass_out", pass_out, e.pass);
					check_flag("last_out", last_out, e.last);
				end
			end else begin
				check_pixel("pxl_out idle", pxl_out, '0);
				check_flag("last_out idle", last_out, 1'b0);
				if (run_len != 0) begin
					check_count("channel run", run_len, IMAGE_SIZE);
				end
				run_len = 0;
				if (started) begin
					gap_len++;
				end
			end
			if (!busy && busy_prev) begin
				// Fall comes the cycle after last_out
				check_flag("last_out before busy fall", last_prev, 1'b1);
				started = 1'b0;
				gap_len = 0;
			end
			busy_prev = busy;
			last_prev = last_out;
		end
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		reset = 1'b1;
		valid_in = 1'b0;
		pxl_in = '0;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		for (int f = 0; f < 3 && !timed_out; f++) begin
			load_frame(1'b0);
			replay_with_noise();
		end
		if (!timed_out) begin
			reset_mid_replay();
		end
		if (!timed_out) begin
			load_frame(1'b0);
			replay_with_noise();
		end
		// Back to back frames where the second starts the cycle busy falls
		if (!timed_out) begin
			load_frame(1'b0);
			replay_with_noise();
		end
		if (!timed_out) begin
			load_frame(1'b1);
			replay_with_noise();
		end
		repeat (4) @(negedge clk);
		$display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
